/* apu_isa_pkg.sv */
package apu_isa_pkg;

	// major opcode in bits 15..12
	typedef enum logic [3:0] {
		OP_LDI   = 4'd0,	// dst = imm8
		OP_ANDI  = 4'd1,
		OP_ORI   = 4'd2,
		OP_XORI  = 4'd3,
		OP_ADDI  = 4'd4,
		OP_TSTI  = 4'd5,	// and, flags only
		OP_CMPI  = 4'd6,	// sub, flags only
		OP_UNARY = 4'd7,	// sub-op in func field
		OP_ALUR  = 4'd9,	// dst = dst op src
		OP_OUT   = 4'd11,	// port = src
		OP_JR    = 4'd12,	// cond in dst field
		OP_DJNZ  = 4'd14,
		OP_HALT  = 4'd15
	} apu_op_e;

	typedef enum logic [3:0] {
		ALU_LD, ALU_AND, ALU_OR, ALU_XOR,
		ALU_ADD, ALU_ADC, ALU_SUB, ALU_SBC,
		ALU_RR, ALU_RRC, ALU_SRA, ALU_SRZ,
		ALU_RL, ALU_RLC, ALU_SWAP, ALU_FLIP
	} alu_func_e;

	// codes 12..15 do nothing
	typedef enum logic [3:0] {
		U_INC, U_DEC, U_CPL, U_NEG,
		U_RR, U_RRC, U_SRA, U_SRZ,
		U_RL, U_RLC, U_SWAP, U_FLIP
	} unary_e;

	typedef enum logic [3:0] {
		J_ALWAYS, J_Z, J_C, J_NZ,
		J_GT, J_LE, J_NC, J_S,
		J_NS, J_LT, J_SLE, J_SGT,
		J_SGE, J_V, J_NV, J_NEVER
	} jcond_e;

	// instruction fields
	localparam int op_hi_c   = 15;
	localparam int op_lo_c   = 12;
	localparam int dst_hi_c  = 11;	// also jump condition
	localparam int dst_lo_c  = 8;
	localparam int port_hi_c = 11;	// out port number
	localparam int port_lo_c = 8;
	localparam int func_hi_c = 7;	// alu func or unary sub-op
	localparam int func_lo_c = 4;
	localparam int src_hi_c  = 3;
	localparam int src_lo_c  = 0;
	localparam int imm_hi_c  = 7;	// imm8 or rel8
	localparam int imm_lo_c  = 0;

	// operand select codes
	localparam logic [1:0] sel_a_c    = 2'd0;	// dst register
	localparam logic [1:0] sel_b_c    = 2'd1;	// src register
	localparam logic [1:0] sel_zero_c = 2'd2;
	localparam logic [1:0] sel_imm_c  = 2'd3;

endpackage

/* apu_map_pkg.sv */
package apu_map_pkg;

	// output port numbers
	localparam logic [3:0] port_covox_c  = 4'd5;	// sound dac byte
	localparam logic [3:0] port_border_c = 4'd6;	// border colour

	// border colour width
	localparam int border_w_c = 6;

	// word that stops the engine and raises ready
	localparam logic [15:0] halt_word_c = 16'hffff;

endpackage

/* apu_code_ram.sv */
module apu_code_ram #(
	parameter int code_aw = 8
) (
	input  logic               clk,
	input  logic               code_wen,
	input  logic [code_aw:0]   code_waddr,	// byte address
	input  logic [7:0]         code_wdata,
	input  logic [code_aw-1:0] rd_addr,
	output logic [15:0]        opcode_raw
);

	logic [15:0]        mem [2**code_aw];	// code words
	logic [7:0]         lo_byte;		// even byte waits here
	logic               mem_we;
	logic [code_aw-1:0] wr_addr;

	assign mem_we  = code_wen && code_waddr[0];	// odd byte completes the word
	assign wr_addr = code_waddr[code_aw:1];

	always_ff @(posedge clk)
	begin
		if (code_wen && !code_waddr[0])
			lo_byte <= code_wdata;
		if (mem_we)
			mem[wr_addr] <= {code_wdata, lo_byte};
		opcode_raw <= mem[rd_addr];	// old data on same-cycle write
	end

	// contents stay put while the host port is idle
	a_no_stray_write: assert property (@(posedge clk)
		!code_wen |=> mem[$past(wr_addr)] === $past(mem[wr_addr]));

endmodule

/* apu_decoder.sv */
module apu_decoder (
	input  logic [15:0]            opcode,
	output apu_isa_pkg::alu_func_e alu_func,
	output logic [3:0]             rd_a,
	output logic [3:0]             rd_b,
	output logic [1:0]             arg0_sel,
	output logic [1:0]             arg1_sel,
	output logic [7:0]             imm,
	output logic                   reg_we,
	output logic                   c_we,
	output logic                   z_we,
	output logic                   s_we,
	output logic                   v_we,
	output logic                   port_we,
	output logic [3:0]             port_num
);

	import apu_isa_pkg::*;

	apu_op_e op;
	unary_e  uop;
	logic    flag_op;	// flags follow the alu func

	assign op       = apu_op_e'(opcode[op_hi_c:op_lo_c]);
	assign uop      = unary_e'(opcode[func_hi_c:func_lo_c]);
	assign rd_a     = opcode[dst_hi_c:dst_lo_c];	// also write target
	assign rd_b     = opcode[src_hi_c:src_lo_c];
	assign port_num = opcode[port_hi_c:port_lo_c];
	assign port_we  = (op == OP_OUT);	// data is src register

	always_comb
	begin
		alu_func = ALU_LD;
		arg0_sel = sel_a_c;
		arg1_sel = sel_imm_c;
		imm      = opcode[imm_hi_c:imm_lo_c];
		reg_we   = 1'b0;
		flag_op  = 1'b0;
		case (op)
			OP_LDI:   reg_we = 1'b1;	// ld gives no flags
			OP_ANDI:  {alu_func, reg_we, flag_op} = {ALU_AND, 2'b11};
			OP_ORI:   {alu_func, reg_we, flag_op} = {ALU_OR, 2'b11};
			OP_XORI:  {alu_func, reg_we, flag_op} = {ALU_XOR, 2'b11};
			OP_ADDI:  {alu_func, reg_we, flag_op} = {ALU_ADD, 2'b11};
			OP_TSTI:  {alu_func, flag_op} = {ALU_AND, 1'b1};
			OP_CMPI:  {alu_func, flag_op} = {ALU_SUB, 1'b1};
			OP_ALUR:
			begin
				alu_func = alu_func_e'(opcode[func_hi_c:func_lo_c]);
				arg1_sel = sel_b_c;
				reg_we   = 1'b1;
				flag_op  = 1'b1;
			end
			OP_UNARY:
			begin
				arg0_sel = sel_b_c;	// acts on src, lands in dst
				reg_we   = (uop <= U_FLIP);	// 12..15 are no-ops
				flag_op  = 1'b1;
				case (uop)
					U_INC: {alu_func, imm} = {ALU_ADD, 8'h01};
					U_DEC: {alu_func, imm} = {ALU_SUB, 8'h01};
					U_CPL: {alu_func, imm} = {ALU_XOR, 8'hff};
					U_NEG:
					begin
						alu_func = ALU_SUB;	// 0 - src
						arg0_sel = sel_zero_c;
						arg1_sel = sel_b_c;
					end
					U_RR:   alu_func = ALU_RR;
					U_RRC:  alu_func = ALU_RRC;
					U_SRA:  alu_func = ALU_SRA;
					U_SRZ:  alu_func = ALU_SRZ;
					U_RL:   alu_func = ALU_RL;
					U_RLC:  alu_func = ALU_RLC;
					U_SWAP: alu_func = ALU_SWAP;
					U_FLIP: alu_func = ALU_FLIP;
					default: flag_op = 1'b0;
				endcase
			end
			OP_DJNZ:  {alu_func, imm, reg_we} = {ALU_SUB, 8'h01, 1'b1};	// flags kept
			default: ;	// out, jr, halt and spare codes
		endcase
	end

	// flag enables per alu func
	always_comb
	begin
		{c_we, z_we, s_we, v_we} = 4'b0000;
		if (flag_op)
			case (alu_func)
				ALU_AND, ALU_OR, ALU_XOR:            {z_we, s_we, v_we} = 3'b111;	// v cleared
				ALU_ADD, ALU_ADC, ALU_SUB, ALU_SBC:  {c_we, z_we, s_we, v_we} = 4'b1111;
				ALU_RR, ALU_RRC, ALU_SRA, ALU_SRZ,
				ALU_RL, ALU_RLC:                     {c_we, z_we, s_we} = 3'b111;
				default: ;	// ld, swap, flip
			endcase
	end

endmodule

/* apu_alu.sv */
module apu_alu #(
	parameter int data_w = 8
) (
	input  apu_isa_pkg::alu_func_e func,
	input  logic [data_w-1:0]      arg0,
	input  logic [data_w-1:0]      arg1,
	input  logic                   c_in,
	output logic [data_w-1:0]      res,
	output logic                   c_out,
	output logic                   z_out,
	output logic                   s_out,
	output logic                   v_out
);

	import apu_isa_pkg::*;

	localparam int msb  = data_w - 1;
	localparam int half = data_w / 2;	// nibble boundary for swap

	logic [data_w:0] sum;	// carry on top
	logic [data_w:0] diff;	// borrow on top
	logic            cy;	// carry into adc or sbc
	logic            add_v;
	logic            sub_v;

	assign cy    = (func == ALU_ADC || func == ALU_SBC) ? c_in : 1'b0;
	assign sum   = {1'b0, arg0} + {1'b0, arg1} + {{data_w{1'b0}}, cy};
	assign diff  = {1'b0, arg0} - {1'b0, arg1} - {{data_w{1'b0}}, cy};
	assign add_v = (arg0[msb] == arg1[msb]) && (sum[msb] != arg0[msb]);	// same signs in
	assign sub_v = (arg0[msb] != arg1[msb]) && (diff[msb] != arg0[msb]);

	always_comb
	begin
		res   = arg1;
		c_out = c_in;	// logic ops keep c
		v_out = 1'b0;
		case (func)
			ALU_LD:  res = arg1;
			ALU_AND: res = arg0 & arg1;
			ALU_OR:  res = arg0 | arg1;
			ALU_XOR: res = arg0 ^ arg1;
			ALU_ADD, ALU_ADC:
			begin
				res   = sum[msb:0];
				c_out = sum[data_w];
				v_out = add_v;
			end
			ALU_SUB, ALU_SBC:
			begin
				res   = diff[msb:0];
				c_out = diff[data_w];	// set when arg0 < arg1
				v_out = sub_v;
			end
			ALU_RR:  {res, c_out} = {arg0[0], arg0[msb:1], arg0[0]};	// around the byte
			ALU_RRC: {res, c_out} = {c_in, arg0[msb:1], arg0[0]};	// through c
			ALU_SRA: {res, c_out} = {arg0[msb], arg0[msb:1], arg0[0]};
			ALU_SRZ: {res, c_out} = {1'b0, arg0[msb:1], arg0[0]};
			ALU_RL:  {c_out, res} = {arg0[msb], arg0[msb-1:0], arg0[msb]};
			ALU_RLC: {c_out, res} = {arg0[msb], arg0[msb-1:0], c_in};
			ALU_SWAP: res = {arg0[half-1:0], arg0[msb:half]};
			ALU_FLIP:
			begin
				for (int i = 0; i < data_w; i++)
					res[i] = arg0[msb-i];	// bit reverse
			end
		endcase
	end

	assign z_out = (res == '0);
	assign s_out = res[msb];

endmodule

/* apu_regfile.sv */
module apu_regfile #(
	parameter int data_w = 8
) (
	input  logic              clk,
	input  logic              rst,
	input  logic [3:0]        rd_a,
	input  logic [3:0]        rd_b,
	output logic [data_w-1:0] val_a,
	output logic [data_w-1:0] val_b,
	input  logic              reg_we,
	input  logic [data_w-1:0] res,
	input  logic              c_we,
	input  logic              z_we,
	input  logic              s_we,
	input  logic              v_we,
	input  logic              c_new,
	input  logic              z_new,
	input  logic              s_new,
	input  logic              v_new,
	output logic              flag_c,
	output logic              flag_z,
	output logic              flag_s,
	output logic              flag_v
);

	logic [data_w-1:0] regs [16];	// general registers

	assign val_a = regs[rd_a];	// dst operand
	assign val_b = regs[rd_b];	// src operand

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < 16; i++)
				regs[i] <= '0;
			{flag_c, flag_z, flag_s, flag_v} <= 4'b0000;
		end
		else
		begin
			if (reg_we)
				regs[rd_a] <= res;	// result always goes to dst
			if (c_we)
				flag_c <= c_new;
			if (z_we)
				flag_z <= z_new;
			if (s_we)
				flag_s <= s_new;
			if (v_we)
				flag_v <= v_new;
		end
	end

endmodule

/* apu_sequencer.sv */
module apu_sequencer #(
	parameter int code_aw = 8
) (
	input  logic               clk,
	input  logic               rst,
	input  logic               apu_halt,
	input  logic [15:0]        opcode_raw,
	input  logic               flag_c,
	input  logic               flag_z,
	input  logic               flag_s,
	input  logic               flag_v,
	input  logic               res_zero,	// djnz counter hit zero
	output logic [15:0]        opcode,
	output logic [code_aw-1:0] pc_next,
	output logic               apu_rdy
);

	import apu_isa_pkg::*;
	import apu_map_pkg::*;

	logic [code_aw-1:0] pc;	// address of the executing word
	logic [code_aw-1:0] pc_inc;
	logic [code_aw-1:0] pc_jump;
	logic [code_aw-1:0] rel;	// sign extended rel8
	logic               lt;	// signed less
	logic               cond_ok;
	apu_op_e            op;

	assign opcode  = apu_halt ? halt_word_c : opcode_raw;	// host holds the engine
	assign op      = apu_op_e'(opcode[op_hi_c:op_lo_c]);
	assign rel     = code_aw'($signed(opcode[imm_hi_c:imm_lo_c]));
	assign pc_inc  = pc + 1'b1;
	assign pc_jump = pc_inc + rel;
	assign lt      = flag_s ^ flag_v;

	always_comb
	begin
		case (jcond_e'(opcode[dst_hi_c:dst_lo_c]))
			J_ALWAYS: cond_ok = 1'b1;
			J_Z:      cond_ok = flag_z;
			J_C:      cond_ok = flag_c;
			J_NZ:     cond_ok = !flag_z;
			J_GT:     cond_ok = !flag_c && !flag_z;	// unsigned
			J_LE:     cond_ok = flag_c || flag_z;
			J_NC:     cond_ok = !flag_c;
			J_S:      cond_ok = flag_s;
			J_NS:     cond_ok = !flag_s;
			J_LT:     cond_ok = lt;
			J_SLE:    cond_ok = lt || flag_z;
			J_SGT:    cond_ok = !(lt || flag_z);
			J_SGE:    cond_ok = !lt;
			J_V:      cond_ok = flag_v;
			J_NV:     cond_ok = !flag_v;
			J_NEVER:  cond_ok = 1'b0;
		endcase
	end

	// ram reads at pc_next so a taken jump costs nothing
	always_comb
	begin
		pc_next = pc_inc;
		if ((op == OP_JR && cond_ok) || (op == OP_DJNZ && !res_zero))
			pc_next = pc_jump;
		if (opcode == halt_word_c)
			pc_next = pc;	// spin on the halt word
		if (rst || apu_halt)
			pc_next = '0;	// fetch word 0 for the first cycle
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			pc      <= '0;
			apu_rdy <= 1'b0;
		end
		else
		begin
			pc      <= pc_next;
			apu_rdy <= (opcode == halt_word_c);
		end
	end

	// a held engine sits on word 0 with ready raised
	a_halt_restart: assert property (@(posedge clk) disable iff (rst)
		apu_halt |=> pc == '0 && apu_rdy);

endmodule

/* apu_out_ports.sv */
module apu_out_ports #(
	parameter int data_w = 8
) (
	input  logic                              clk,
	input  logic                              rst,
	input  logic                              port_we,
	input  logic [3:0]                        port_num,
	input  logic [data_w-1:0]                 data,
	output logic [7:0]                        covox,
	output logic                              covox_we,
	output logic [apu_map_pkg::border_w_c-1:0] border,
	output logic                              border_we
);

	import apu_map_pkg::*;

	logic hit_covox;
	logic hit_border;

	assign hit_covox  = port_we && (port_num == port_covox_c);
	assign hit_border = port_we && (port_num == port_border_c);	// other ports dropped

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			covox     <= '0;
			covox_we  <= 1'b0;
			border    <= '0;
			border_we <= 1'b0;
		end
		else
		begin
			covox_we  <= hit_covox;	// one cycle pulse
			border_we <= hit_border;
			if (hit_covox)
				covox <= data[7:0];
			if (hit_border)
				border <= data[border_w_c-1:0];	// low bits only
		end
	end

	// at most one pulse, and only after an out
	a_one_pulse: assert property (@(posedge clk) disable iff (rst)
		(covox_we || border_we) |-> !(covox_we && border_we) && $past(port_we));

endmodule

/* apu.sv */
module apu (
	input  logic       clk,
	input  logic       rst,
	input  logic       apu_halt,
	input  logic       code_wen,
	input  logic [8:0] code_waddr,
	input  logic [7:0] code_wdata,
	output logic       apu_rdy,
	output logic [7:0] covox,
	output logic       covox_we,
	output logic [5:0] border,
	output logic       border_we
);

	import apu_isa_pkg::*;

	localparam int code_aw = 8;	// 256 code words
	localparam int data_w  = 8;

	logic [15:0]        opcode_raw;	// registered ram output
	logic [15:0]        opcode;	// after halt forcing
	logic [code_aw-1:0] pc_next;
	alu_func_e          alu_func;
	logic [3:0]         rd_a;
	logic [3:0]         rd_b;
	logic [1:0]         arg0_sel;
	logic [1:0]         arg1_sel;
	logic [7:0]         imm;
	logic               reg_we;
	logic               c_we;
	logic               z_we;
	logic               s_we;
	logic               v_we;
	logic               port_we;
	logic [3:0]         port_num;
	logic [data_w-1:0]  val_a;
	logic [data_w-1:0]  val_b;
	logic [data_w-1:0]  arg0;
	logic [data_w-1:0]  arg1;
	logic [data_w-1:0]  res;
	logic               c_new;
	logic               z_new;	// also the djnz zero test
	logic               s_new;
	logic               v_new;
	logic               flag_c;
	logic               flag_z;
	logic               flag_s;
	logic               flag_v;

	// operand muxes
	assign arg0 = (arg0_sel == sel_zero_c) ? '0 : (arg0_sel == sel_b_c) ? val_b : val_a;
	assign arg1 = (arg1_sel == sel_imm_c) ? data_w'(imm) : val_b;

	apu_code_ram #(.code_aw(code_aw)) code_ram0 (
		.clk(clk), .code_wen(code_wen), .code_waddr(code_waddr), .code_wdata(code_wdata),
		.rd_addr(pc_next), .opcode_raw(opcode_raw));

	apu_sequencer #(.code_aw(code_aw)) seq0 (
		.clk(clk), .rst(rst), .apu_halt(apu_halt), .opcode_raw(opcode_raw),
		.flag_c(flag_c), .flag_z(flag_z), .flag_s(flag_s), .flag_v(flag_v),
		.res_zero(z_new), .opcode(opcode), .pc_next(pc_next), .apu_rdy(apu_rdy));

	apu_decoder dec0 (
		.opcode(opcode), .alu_func(alu_func), .rd_a(rd_a), .rd_b(rd_b),
		.arg0_sel(arg0_sel), .arg1_sel(arg1_sel), .imm(imm), .reg_we(reg_we),
		.c_we(c_we), .z_we(z_we), .s_we(s_we), .v_we(v_we),
		.port_we(port_we), .port_num(port_num));

	apu_regfile #(.data_w(data_w)) regs0 (
		.clk(clk), .rst(rst), .rd_a(rd_a), .rd_b(rd_b), .val_a(val_a), .val_b(val_b),
		.reg_we(reg_we), .res(res), .c_we(c_we), .z_we(z_we), .s_we(s_we), .v_we(v_we),
		.c_new(c_new), .z_new(z_new), .s_new(s_new), .v_new(v_new),
		.flag_c(flag_c), .flag_z(flag_z), .flag_s(flag_s), .flag_v(flag_v));

	apu_alu #(.data_w(data_w)) alu0 (
		.func(alu_func), .arg0(arg0), .arg1(arg1), .c_in(flag_c), .res(res),
		.c_out(c_new), .z_out(z_new), .s_out(s_new), .v_out(v_new));

	apu_out_ports #(.data_w(data_w)) ports0 (
		.clk(clk), .rst(rst), .port_we(port_we), .port_num(port_num), .data(val_b),
		.covox(covox), .covox_we(covox_we), .border(border), .border_we(border_we));

endmodule

/* tb_apu.sv */
module tb_apu;

	timeunit 1ns;
	timeprecision 100ps;

	logic       clk;
	logic       rst;
	logic       apu_halt;
	logic       code_wen;
	logic [8:0] code_waddr;
	logic [7:0] code_wdata;
	logic       apu_rdy;
	logic [7:0] covox;
	logic       covox_we;
	logic [5:0] border;
	logic       border_we;

	logic [15:0] progs [5][256];	// program words
	int          plen [5];
	logic [11:0] exp_q [$];	// {port, value}
	logic [31:0] lfsr_state;
	int          errors;
	int          covox_pulses;
	real         limit_ns;

	apu dut0 (
		.clk(clk), .rst(rst), .apu_halt(apu_halt), .code_wen(code_wen),
		.code_waddr(code_waddr), .code_wdata(code_wdata), .apu_rdy(apu_rdy),
		.covox(covox), .covox_we(covox_we), .border(border), .border_we(border_we));

	always #10 clk = !clk;

	// taps 32, 22, 2, 1
	function automatic logic [31:0] take_bits(input int n);
		logic        fb;
		logic [31:0] val;
		val = '0;
		for (int i = 0; i < n; i++)
		begin
			fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], fb};
			val = {val[30:0], fb};
		end
		return val;
	endfunction

	task automatic emit(input int p, input logic [15:0] w);
		progs[p][plen[p]] = w;
		plen[p]++;
	endtask

	function automatic logic [7:0] arith(input logic [7:0] a, input logic [7:0] b,
			input logic cin, input logic sub, output logic co, output logic vo);
		int t;
		int ts;	// signed view for overflow
		logic [7:0] r;
		if (sub)
		begin
			t = int'(a) - int'(b) - int'(cin);
			ts = int'($signed(a)) - int'($signed(b)) - int'(cin);
			r = t[7:0];
			co = (t < 0);	// borrow
			vo = (ts < -128) || (ts > 127);
		end
		else
		begin
			t = int'(a) + int'(b) + int'(cin);
			ts = int'($signed(a)) + int'($signed(b)) + int'(cin);
			r = t[7:0];
			co = (t > 255);
			vo = (ts < -128) || (ts > 127);
		end
		return r;
	endfunction

	// unary codes 4..9
	function automatic logic [7:0] shift(input logic [3:0] u, input logic [7:0] a,
			input logic cin, output logic co);
		co = (u >= 8) ? a[7] : a[0];
		case (u)
			4: return {a[0], a[7:1]};
			5: return {cin, a[7:1]};
			6: return {a[7], a[7:1]};
			7: return {1'b0, a[7:1]};
			8: return {a[6:0], a[7]};
			default: return {a[6:0], cin};
		endcase
	endfunction

	function automatic logic cond_true(input logic [3:0] k, input logic c, input logic z,
			input logic s, input logic v);
		logic lt;
		lt = s ^ v;
		case (k)
			0: return 1'b1;
			1: return z;
			2: return c;
			3: return !z;
			4: return !c && !z;
			5: return c || z;
			6: return !c;
			7: return s;
			8: return !s;
			9: return lt;
			10: return lt || z;
			11: return !(lt || z);
			12: return !lt;
			13: return v;
			14: return !v;
			default: return 1'b0;
		endcase
	endfunction

	// runs program p by the isa rules, queues its port writes, returns step count
	function automatic int interp(input int p);
		logic [7:0]  r [16];
		logic        c, z, s, v;
		logic [7:0]  pc;
		logic [7:0]  a;
		logic [7:0]  res;
		logic [15:0] w;
		logic [3:0]  op, d, f, sr;
		logic        wr, fl_zs, jmp;
		int          steps;
		for (int i = 0; i < 16; i++)
			r[i] = 8'h00;
		{c, z, s, v} = 4'b0000;
		pc = 8'h00;
		steps = 0;
		w = 16'h0000;
		while (w != 16'hffff && steps < 5000)
		begin
			w = progs[p][pc];
			{op, d, f, sr} = w;
			steps++;
			wr = 1'b0;
			fl_zs = 1'b0;
			jmp = 1'b0;
			res = 8'h00;
			case (op)
				0: {res, wr} = {w[7:0], 1'b1};
				1, 2, 3, 5:
				begin
					res = (op == 2) ? (r[d] | w[7:0]) : (op == 3) ? (r[d] ^ w[7:0]) : (r[d] & w[7:0]);
					{wr, fl_zs, v} = {op != 5, 2'b10};
				end
				4, 6:
				begin
					res = arith(r[d], w[7:0], 1'b0, op == 6, c, v);
					{wr, fl_zs} = {op == 4, 1'b1};
				end
				7:
				begin
					a = r[sr];
					wr = (f <= 11);
					fl_zs = (f <= 9);
					case (f)
						0: res = arith(a, 8'h01, 1'b0, 1'b0, c, v);
						1: res = arith(a, 8'h01, 1'b0, 1'b1, c, v);
						2: {res, v} = {~a, 1'b0};
						3: res = arith(8'h00, a, 1'b0, 1'b1, c, v);
						4, 5, 6, 7, 8, 9: res = shift(f, a, c, c);
						10: res = {a[3:0], a[7:4]};
						11: for (int i = 0; i < 8; i++) res[i] = a[7-i];
						default: ;
					endcase
				end
				9:
				begin
					wr = 1'b1;
					fl_zs = (f >= 1 && f <= 13);
					case (f)
						0: res = r[sr];
						1: {res, v} = {r[d] & r[sr], 1'b0};
						2: {res, v} = {r[d] | r[sr], 1'b0};
						3: {res, v} = {r[d] ^ r[sr], 1'b0};
						4, 5, 6, 7: res = arith(r[d], r[sr], (f == 5 || f == 7) && c, f >= 6, c, v);
						14: res = {r[d][3:0], r[d][7:4]};
						15: for (int i = 0; i < 8; i++) res[i] = r[d][7-i];
						default: res = shift(f - 4'd4, r[d], c, c);
					endcase
				end
				11:
				begin
					if (d == 5)
						exp_q.push_back({4'd5, r[sr]});
					if (d == 6)
						exp_q.push_back({4'd6, 2'b00, r[sr][5:0]});
				end
				12: jmp = cond_true(d, c, z, s, v);
				14:
				begin
					r[d] = r[d] - 8'h01;	// flags untouched
					jmp = (r[d] != 8'h00);
				end
				default: ;
			endcase
			if (wr)
				r[d] = res;
			if (fl_zs)
				{z, s} = {res == 8'h00, res[7]};
			if (w != 16'hffff)
				pc = jmp ? pc + 8'd1 + w[7:0] : pc + 8'd1;
		end
		return steps;
	endfunction

	task automatic load_prog(input int p);
		for (int i = 0; i < plen[p]; i++)
			for (int h = 0; h < 2; h++)
			begin
				@(posedge clk);
				#2;
				code_wen = 1'b1;
				code_waddr = 9'(2 * i + h);
				code_wdata = h ? progs[p][i][15:8] : progs[p][i][7:0];
			end
		@(posedge clk);
		#2;
		code_wen = 1'b0;
	endtask

	task automatic run_prog(input int p, input int exp_covox);
		int steps;
		int cycles;
		load_prog(p);
		exp_q.delete();
		steps = interp(p);
		covox_pulses = 0;
		apu_halt = 1'b0;	// restart at word 0
		@(negedge clk);	// ready still up from the hold
		@(negedge clk);
		cycles = 1;
		while (!apu_rdy)
		begin
			@(negedge clk);
			cycles++;
		end
		if (cycles != steps)
		begin
			$display("program %0d reached halt after %0d cycles instead of %0d", p,
				cycles, steps);
			errors++;
		end
		for (int i = 0; i < 3; i++)
		begin
			@(negedge clk);	// extra pulses would show here
			if (!apu_rdy)
			begin
				$display("apu_rdy fell while program %0d sat on the halt word", p);
				errors++;
			end
		end
		if (exp_q.size() != 0)
			begin
				$display("program %0d ended with %0d port writes missing", p, exp_q.size());
				errors++;
			end
		if (exp_covox >= 0 && covox_pulses != exp_covox)
			begin
				$display("program %0d gave %0d covox pulses instead of %0d", p, covox_pulses,
					exp_covox);
				errors++;
			end
		@(posedge clk);
		#2;
		apu_halt = 1'b1;
		repeat (2) @(negedge clk);
	endtask

	// pops the expected queue on each pulse
	always @(negedge clk)
		if (!rst && (covox_we || border_we))
		begin
			if (covox_we)
				covox_pulses++;
			if (covox_we && border_we)
			begin
				$display("covox and border pulses came in the same cycle");
				errors++;
			end
			else if (exp_q.size() == 0)
			begin
				$display("unexpected output pulse at %0t", $time);
				errors++;
			end
			else if (covox_we && exp_q[0][11:8] != 4'd5)
			begin
				$display("covox pulse came where a border write was expected");
				errors++;
				void'(exp_q.pop_front());
			end
			else if (border_we && exp_q[0][11:8] != 4'd6)
			begin
				$display("border pulse came where a covox write was expected");
				errors++;
				void'(exp_q.pop_front());
			end
			else if (covox_we && covox != exp_q[0][7:0])
			begin
				$display("ERR covox got %h expected %h", covox, exp_q[0][7:0]);
				errors++;
				void'(exp_q.pop_front());
			end
			else if (border_we && border != exp_q[0][5:0])
			begin
				$display("ERR border got %h expected %h", border, exp_q[0][5:0]);
				errors++;
				void'(exp_q.pop_front());
			end
			else
				void'(exp_q.pop_front());
		end

	// budget follows the program lengths
	initial
	begin
		wait (limit_ns > 0.0);
		#(limit_ns);
		$display("timeout: the engine never reached halt");
		$display("Something failed");
		$finish;
	end

	initial
	begin
		logic [31:0] x;
		logic [31:0] y;
		int          cnt;
		int          total;
		int          n;
		clk = 1'b0;
		rst = 1'b1;
		apu_halt = 1'b1;
		code_wen = 1'b0;
		code_waddr = '0;
		code_wdata = '0;
		errors = 0;
		covox_pulses = 0;
		limit_ns = 0.0;
		lfsr_state = 32'h4ece;
		for (int p = 0; p < 5; p++)
			plen[p] = 0;

		// immediate ops
		for (int i = 0; i < 4; i++)
		begin
			x = take_bits(8);
			emit(0, {4'd0, 4'd1, x[7:0]});
			for (int k = 1; k <= 4; k++)
			begin
				x = take_bits(8);
				emit(0, {4'(k), 4'd1, x[7:0]});
				emit(0, {4'd11, 4'd5, 4'd0, 4'd1});
			end
		end
		emit(0, 16'hffff);
		// reg-reg arithmetic then every jump condition
		for (int k = 0; k < 16; k++)
		begin
			x = take_bits(8);
			y = take_bits(8);
			emit(1, {4'd0, 4'd4, 8'(k + 32)});	// marker
			emit(1, {4'd0, 4'd2, x[7:0]});
			emit(1, {4'd0, 4'd3, y[7:0]});
			emit(1, {4'd9, 4'd2, 4'(4 + k % 4), 4'd3});
			emit(1, {4'd11, 4'd5, 4'd0, 4'd2});
			emit(1, {4'd12, 4'(k), 8'd1});
			emit(1, {4'd12, 4'd0, 8'd1});
			emit(1, {4'd11, 4'd6, 4'd0, 4'd4});
		end
		emit(1, 16'hffff);
		// djnz loop
		x = take_bits(5);
		cnt = x % 20 + 1;
		emit(2, {4'd0, 4'd5, 8'(cnt)});
		emit(2, {4'd0, 4'd6, 8'h00});
		emit(2, {4'd4, 4'd6, 8'h01});
		emit(2, {4'd11, 4'd5, 4'd0, 4'd6});
		emit(2, {4'd14, 4'd5, 8'hfd});	// back to the addi
		emit(2, 16'hffff);
		// unary ops, cmpi first for a random carry
		for (int u = 0; u < 12; u++)
		begin
			x = take_bits(8);
			y = take_bits(8);
			emit(3, {4'd0, 4'd7, x[7:0]});
			emit(3, {4'd6, 4'd7, y[7:0]});
			emit(3, {4'd7, 4'd8, 4'(u), 4'd7});
			emit(3, {4'd11, 4'd5, 4'd0, 4'd8});
		end
		emit(3, 16'hffff);
		// short program for the restart
		x = take_bits(8);
		y = take_bits(8);
		emit(4, {4'd0, 4'd9, x[7:0]});
		emit(4, {4'd11, 4'd6, 4'd0, 4'd9});
		emit(4, {4'd3, 4'd9, y[7:0]});
		emit(4, {4'd11, 4'd5, 4'd0, 4'd9});
		emit(4, 16'hffff);

		total = 20;
		for (int p = 0; p < 5; p++)
			total += 2 * plen[p] + interp(p) + 20;
		exp_q.delete();
		limit_ns = total * 20.0 + 2000.0;

		repeat (4) @(posedge clk);
		#2;
		rst = 1'b0;
		n = 0;
		while (!apu_rdy && n < 10)
		begin
			@(negedge clk);
			n++;
		end
		if (!apu_rdy)
		begin
			$display("apu_rdy did not rise while apu_halt was held");
			errors++;
		end

		run_prog(0, -1);
		run_prog(1, -1);
		run_prog(2, cnt);
		run_prog(3, -1);
		repeat (5) @(negedge clk);	// pulses stop under halt
		run_prog(4, -1);

		$display("checks done, %0d errors", errors);
		if (errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

/* files.f */
apu_isa_pkg.sv
apu_map_pkg.sv
apu_code_ram.sv
apu_decoder.sv
apu_alu.sv
apu_regfile.sv
apu_sequencer.sv
apu_out_ports.sv
apu.sv
tb_apu.sv

/* run.sh */
#!/bin/bash
# builds and runs the apu testbench with Verilator
cd "$(dirname "$0")" &&
	verilator --binary --timing --assert -f files.f --top-module tb_apu -o sim_apu &&
	./obj_dir/sim_apu | tee /dev/stderr | grep -q "^Everything OK$" &&
	echo "PASS" || { echo "FAIL"; exit 1; }
